/* source/sdram_params.svh */
`ifndef SDRAM_PARAMS_SVH
`define SDRAM_PARAMS_SVH

`default_nettype none

// request address split: row [25:14], bank [13:12], column [11:0]
`define SDRAM_ADDR_W 26
`define SDRAM_ROW_W 12
`define SDRAM_BANK_W 2
`define SDRAM_COL_W 12

`define SDRAM_BUS_W 13         // device address bus
`define SDRAM_ADDR_IDLE 13'h0400  // A10 set, precharge all

// minimum spacing in clocks from a command to the next one
`define SDRAM_T_ACTV 3
`define SDRAM_T_RW 3
`define SDRAM_T_PRCH 3
`define SDRAM_T_REF 10
`define SDRAM_T_RAS 6          // ACTV to PRCH

`define SDRAM_REFRESH_PERIOD 200  // short period for simulation
`define SDRAM_TIMER_W 8

`default_nettype wire

`endif

/* source/sdram_pkg.sv */
`default_nettype none

package sdram_pkg;

  // command encodings as seen on the {ras_n, cas_n, we_n} pins
  typedef enum logic [2:0] {
    MRST = 3'b000,  // mode register set
    ARSR = 3'b001,  // auto refresh
    PRCH = 3'b010,  // precharge, row close
    ACTV = 3'b011,  // activate, row open
    WRTE = 3'b100,
    READ = 3'b101,
    BTRM = 3'b110,  // burst terminate
    NOOP = 3'b111
  } sdram_cmd_e;

endpackage

`default_nettype wire

/* source/refresh_timer.sv */
`timescale 1ns/1ns
`include "sdram_params.svh"
`default_nettype none

module refresh_timer (
  input  logic CLK,
  input  logic RST,
  input  logic refresh_ack,
  output logic refresh_due
);

  localparam logic [`SDRAM_TIMER_W-1:0] period_load = `SDRAM_REFRESH_PERIOD - 1;

  logic [`SDRAM_TIMER_W-1:0] count;

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      count       <= period_load;
      refresh_due <= 1'b0;
    end
    else
    begin
      if (count == '0)
      begin
        count       <= period_load;  // reload at the due point, no drift
        refresh_due <= 1'b1;         // a new due point beats a late ack
      end
      else
      begin
        count <= count - 1'b1;
        if (refresh_ack)
          refresh_due <= 1'b0;
      end
    end
  end

endmodule

`default_nettype wire

/* source/page_tracker.sv */
`timescale 1ns/1ns
`include "sdram_params.svh"
`default_nettype none

module page_tracker (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     cmd_issue,
  input  sdram_pkg::sdram_cmd_e    cmd,
  input  logic [`SDRAM_ADDR_W-1:0] act_addr,
  input  logic                     rand_req,
  input  logic [`SDRAM_ADDR_W-1:0] rand_addr,
  input  logic                     bulk_req,
  input  logic [`SDRAM_ADDR_W-1:0] bulk_addr,
  output logic                     page_open,
  output logic                     hit_rand,
  output logic                     hit_bulk
);

  logic [`SDRAM_ROW_W-1:0]  open_row;
  logic [`SDRAM_BANK_W-1:0] open_bank;
  logic [`SDRAM_ROW_W-1:0]  rand_row;
  logic [`SDRAM_BANK_W-1:0] rand_bank;
  logic [`SDRAM_ROW_W-1:0]  bulk_row;
  logic [`SDRAM_BANK_W-1:0] bulk_bank;

  assign rand_row  = rand_addr[`SDRAM_ADDR_W-1 -: `SDRAM_ROW_W];
  assign rand_bank = rand_addr[`SDRAM_COL_W +: `SDRAM_BANK_W];
  assign bulk_row  = bulk_addr[`SDRAM_ADDR_W-1 -: `SDRAM_ROW_W];
  assign bulk_bank = bulk_addr[`SDRAM_COL_W +: `SDRAM_BANK_W];

  // Only ACTV or ARSR can be issued while no page is open. Capturing on
  // ARSR is harmless since page_open stays low until an ACTV is on the bus.
  always_ff @(posedge CLK)
  begin
    if (cmd_issue && !page_open)
    begin
      open_row  <= act_addr[`SDRAM_ADDR_W-1 -: `SDRAM_ROW_W];
      open_bank <= act_addr[`SDRAM_COL_W +: `SDRAM_BANK_W];
    end
  end

  // cmd is the registered bus, so the page flag follows one cycle later
  always_ff @(posedge CLK)
  begin
    if (!RST)
      page_open <= 1'b0;
    else if (cmd == sdram_pkg::ACTV)
      page_open <= 1'b1;
    else if (cmd == sdram_pkg::PRCH)
      page_open <= 1'b0;
  end

  assign hit_rand = rand_req && page_open &&
                    (rand_row == open_row) && (rand_bank == open_bank);
  assign hit_bulk = bulk_req && page_open &&
                    (bulk_row == open_row) && (bulk_bank == open_bank);

endmodule

`default_nettype wire

/* source/cmd_timer.sv */
`timescale 1ns/1ns
`include "sdram_params.svh"
`default_nettype none

module cmd_timer (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  cmd_issue,
  input  sdram_pkg::sdram_cmd_e cmd,
  output logic                  cmd_ready,
  output logic                  ras_done
);

  // loads are two short, one cycle for the decision and one for the bus
  localparam logic [`SDRAM_TIMER_W-1:0] spc_actv = `SDRAM_T_ACTV - 2;
  localparam logic [`SDRAM_TIMER_W-1:0] spc_rw   = `SDRAM_T_RW - 2;
  localparam logic [`SDRAM_TIMER_W-1:0] spc_prch = `SDRAM_T_PRCH - 2;
  localparam logic [`SDRAM_TIMER_W-1:0] spc_ref  = `SDRAM_T_REF - 2;
  localparam logic [`SDRAM_TIMER_W-1:0] spc_ras  = `SDRAM_T_RAS - 2;

  logic                      issue_hold;  // command in flight to the bus
  logic [`SDRAM_TIMER_W-1:0] spc_cnt;
  logic [`SDRAM_TIMER_W-1:0] ras_cnt;
  logic [`SDRAM_TIMER_W-1:0] spc_load;

  always_comb
  begin
    case (cmd)
      sdram_pkg::ACTV:                  spc_load = spc_actv;
      sdram_pkg::READ, sdram_pkg::WRTE: spc_load = spc_rw;
      sdram_pkg::PRCH:                  spc_load = spc_prch;
      sdram_pkg::ARSR:                  spc_load = spc_ref;
      default:                          spc_load = '0;
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      issue_hold <= 1'b0;
      spc_cnt    <= '0;
      ras_cnt    <= '0;
    end
    else
    begin
      issue_hold <= cmd_issue;
      if (cmd != sdram_pkg::NOOP)
        spc_cnt <= spc_load;  // command now on the bus
      else if (spc_cnt != '0)
        spc_cnt <= spc_cnt - 1'b1;
      if (cmd == sdram_pkg::ACTV)
        ras_cnt <= spc_ras;
      else if (ras_cnt != '0)
        ras_cnt <= ras_cnt - 1'b1;
    end
  end

  assign cmd_ready = !issue_hold && (spc_cnt == '0);
  assign ras_done  = (ras_cnt == '0) && (cmd != sdram_pkg::ACTV);

endmodule

`default_nettype wire

/* source/cmd_scheduler.sv */
`timescale 1ns/1ns
`include "sdram_params.svh"
`default_nettype none

module cmd_scheduler (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic [`SDRAM_ADDR_W-1:0] rand_addr,
  input  logic                     rand_we,
  input  logic                     rand_req,
  output logic                     rand_grant,
  input  logic [`SDRAM_ADDR_W-1:0] bulk_addr,
  input  logic                     bulk_we,
  input  logic                     bulk_req,
  output logic                     bulk_grant,
  input  logic                     refresh_due,
  output logic                     refresh_ack,
  input  logic                     page_open,
  input  logic                     hit_rand,
  input  logic                     hit_bulk,
  input  logic                     cmd_ready,
  input  logic                     ras_done,
  output logic                     cmd_issue,
  output logic [`SDRAM_ADDR_W-1:0] act_addr,
  output sdram_pkg::sdram_cmd_e    cmd,
  output logic [`SDRAM_BUS_W-1:0]  addr,
  output logic [`SDRAM_BANK_W-1:0] bank
);

  sdram_pkg::sdram_cmd_e    nxt_cmd;
  logic                     use_bulk;
  logic                     any_req;
  logic                     any_hit;
  logic                     sel_we;
  logic                     is_access;
  logic [`SDRAM_ROW_W-1:0]  act_row;
  logic [`SDRAM_BANK_W-1:0] act_bank;
  logic [`SDRAM_COL_W-1:0]  act_col;

  assign any_req = rand_req || bulk_req;
  assign any_hit = hit_rand || hit_bulk;

  // bulk wins, except that a random hit goes ahead of a bulk miss
  assign use_bulk = hit_bulk || (!hit_rand && bulk_req);
  assign act_addr = use_bulk ? bulk_addr : rand_addr;
  assign sel_we   = use_bulk ? bulk_we : rand_we;

  assign act_row  = act_addr[`SDRAM_ADDR_W-1 -: `SDRAM_ROW_W];
  assign act_bank = act_addr[`SDRAM_COL_W +: `SDRAM_BANK_W];
  assign act_col  = act_addr[`SDRAM_COL_W-1:0];

  always_comb
  begin
    nxt_cmd = sdram_pkg::NOOP;
    if (cmd_ready)
    begin
      if (refresh_due)
      begin
        if (!page_open)
          nxt_cmd = sdram_pkg::ARSR;
        else if (ras_done)
          nxt_cmd = sdram_pkg::PRCH;  // close the page before refresh
      end
      else if (any_hit)
      begin
        nxt_cmd = sel_we ? sdram_pkg::WRTE : sdram_pkg::READ;
      end
      else if (any_req)
      begin
        if (!page_open)
          nxt_cmd = sdram_pkg::ACTV;
        else if (ras_done)
          nxt_cmd = sdram_pkg::PRCH;  // page miss
      end
    end
  end

  assign cmd_issue = (nxt_cmd != sdram_pkg::NOOP);
  assign is_access = (nxt_cmd == sdram_pkg::READ) || (nxt_cmd == sdram_pkg::WRTE);

  always_ff @(posedge CLK)
  begin
    if (!RST)
    begin
      cmd         <= sdram_pkg::NOOP;
      addr        <= `SDRAM_ADDR_IDLE;
      bank        <= '0;
      rand_grant  <= 1'b0;
      bulk_grant  <= 1'b0;
      refresh_ack <= 1'b0;
    end
    else
    begin
      cmd         <= nxt_cmd;
      rand_grant  <= is_access && !use_bulk;  // same edge as READ/WRTE
      bulk_grant  <= is_access && use_bulk;
      refresh_ack <= (nxt_cmd == sdram_pkg::ARSR);
      case (nxt_cmd)
        sdram_pkg::ACTV:
        begin
          addr <= {{(`SDRAM_BUS_W - `SDRAM_ROW_W){1'b0}}, act_row};
          bank <= act_bank;
        end
        sdram_pkg::READ, sdram_pkg::WRTE:
        begin
          addr <= {act_col, 1'b0};  // column in [12:1]
          bank <= act_bank;
        end
        default:
        begin
          addr <= `SDRAM_ADDR_IDLE;  // bank keeps its value
        end
      endcase
    end
  end

endmodule

`default_nettype wire

/* source/sdram_ctrl_top.sv */
`timescale 1ns/1ns
`include "sdram_params.svh"
`default_nettype none

module sdram_ctrl_top (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic [`SDRAM_ADDR_W-1:0] rand_addr,
  input  logic                     rand_we,
  input  logic                     rand_req,
  output logic                     rand_grant,
  input  logic [`SDRAM_ADDR_W-1:0] bulk_addr,
  input  logic                     bulk_we,
  input  logic                     bulk_req,
  output logic                     bulk_grant,
  output sdram_pkg::sdram_cmd_e    cmd,
  output logic [`SDRAM_BUS_W-1:0]  addr,
  output logic [`SDRAM_BANK_W-1:0] bank
);

  logic                     refresh_due;
  logic                     refresh_ack;
  logic                     page_open;
  logic                     hit_rand;
  logic                     hit_bulk;
  logic                     cmd_ready;
  logic                     ras_done;
  logic                     cmd_issue;
  logic [`SDRAM_ADDR_W-1:0] act_addr;

  refresh_timer u_refresh (
    .CLK         (CLK),
    .RST         (RST),
    .refresh_ack (refresh_ack),
    .refresh_due (refresh_due)
  );

  page_tracker u_pages (
    .CLK       (CLK),
    .RST       (RST),
    .cmd_issue (cmd_issue),
    .cmd       (cmd),  // registered bus command
    .act_addr  (act_addr),
    .rand_req  (rand_req),
    .rand_addr (rand_addr),
    .bulk_req  (bulk_req),
    .bulk_addr (bulk_addr),
    .page_open (page_open),
    .hit_rand  (hit_rand),
    .hit_bulk  (hit_bulk)
  );

  cmd_timer u_timer (
    .CLK       (CLK),
    .RST       (RST),
    .cmd_issue (cmd_issue),
    .cmd       (cmd),
    .cmd_ready (cmd_ready),
    .ras_done  (ras_done)
  );

  cmd_scheduler u_sched (
    .CLK         (CLK),
    .RST         (RST),
    .rand_addr   (rand_addr),
    .rand_we     (rand_we),
    .rand_req    (rand_req),
    .rand_grant  (rand_grant),
    .bulk_addr   (bulk_addr),
    .bulk_we     (bulk_we),
    .bulk_req    (bulk_req),
    .bulk_grant  (bulk_grant),
    .refresh_due (refresh_due),
    .refresh_ack (refresh_ack),
    .page_open   (page_open),
    .hit_rand    (hit_rand),
    .hit_bulk    (hit_bulk),
    .cmd_ready   (cmd_ready),
    .ras_done    (ras_done),
    .cmd_issue   (cmd_issue),
    .act_addr    (act_addr),
    .cmd         (cmd),
    .addr        (addr),
    .bank        (bank)
  );

endmodule

`default_nettype wire

/* testbench/sdram_cmd_monitor.sv */
`timescale 1ns/1ns
`include "sdram_params.svh"
`default_nettype none

module sdram_cmd_monitor (
  input  logic                     CLK,
  input  logic                     RST,
  input  sdram_pkg::sdram_cmd_e    cmd,
  input  logic [`SDRAM_BUS_W-1:0]  addr,
  input  logic [`SDRAM_BANK_W-1:0] bank,
  output int                       violations,
  output logic                     page_open,
  output logic [`SDRAM_ROW_W-1:0]  open_row,
  output logic [`SDRAM_BANK_W-1:0] open_bank
);

  int cycle;
  int last_cycle;
  int last_gap;    // spacing owed to the previous command
  int actv_cycle;

  task automatic report_violation(input string msg);
    violations = violations + 1;
    $display("monitor: %s at bus cycle %0d", msg, cycle);
  endtask

  always @(posedge CLK)
  begin
    if (!RST)
    begin
      cycle      = 0;
      last_cycle = 0;
      last_gap   = 0;
      actv_cycle = 0;
      violations = 0;
      page_open  = 1'b0;
      open_row   = '0;
      open_bank  = '0;
    end
    else
    begin
      cycle = cycle + 1;
      if (cmd != sdram_pkg::NOOP)
      begin
        if (cycle - last_cycle < last_gap)
          report_violation("command spacing shorter than the previous command needs");
        if (cmd == sdram_pkg::ACTV)
        begin
          if (page_open)
            report_violation("ACTV while a page is already open");
          page_open  = 1'b1;
          open_row   = addr[`SDRAM_ROW_W-1:0];  // row sits in the low bits
          open_bank  = bank;
          actv_cycle = cycle;
        end
        if ((cmd == sdram_pkg::READ || cmd == sdram_pkg::WRTE) && !page_open)
          report_violation("READ or WRTE with no page open");
        if (cmd == sdram_pkg::PRCH)
        begin
          if (page_open && (cycle - actv_cycle < `SDRAM_T_RAS))
            report_violation("PRCH before the minimum row open time");
          page_open = 1'b0;
        end
        case (cmd)
          sdram_pkg::ACTV:                  last_gap = `SDRAM_T_ACTV;
          sdram_pkg::READ, sdram_pkg::WRTE: last_gap = `SDRAM_T_RW;
          sdram_pkg::PRCH:                  last_gap = `SDRAM_T_PRCH;
          sdram_pkg::ARSR:                  last_gap = `SDRAM_T_REF;
          default:                          last_gap = 1;
        endcase
        last_cycle = cycle;
      end
    end
  end

endmodule

`default_nettype wire

/* testbench/sdram_ctrl_tb.sv */
`timescale 1ns/1ns
`include "sdram_params.svh"
`default_nettype none

module sdram_ctrl_tb;

  logic                     CLK;
  logic                     RST;
  logic [`SDRAM_ADDR_W-1:0] rand_addr;
  logic                     rand_we;
  logic                     rand_req;
  logic                     rand_grant;
  logic [`SDRAM_ADDR_W-1:0] bulk_addr;
  logic                     bulk_we;
  logic                     bulk_req;
  logic                     bulk_grant;
  sdram_pkg::sdram_cmd_e    cmd;
  logic [`SDRAM_BUS_W-1:0]  addr;
  logic [`SDRAM_BANK_W-1:0] bank;
  int                       violations;
  logic                     mon_open;
  logic [`SDRAM_ROW_W-1:0]  mon_row;
  logic [`SDRAM_BANK_W-1:0] mon_bank;

  logic [31:0]              lcg_state;
  logic [`SDRAM_ADDR_W-1:0] page_addr;  // address of the page left open
  string                    test_name;
  int                       errors;
  int                       start_errs;
  int                       passed;
  int                       failed;

  // command log, one entry per bus command
  int                       cyc;
  sdram_pkg::sdram_cmd_e    log_cmd[$];
  logic [`SDRAM_BUS_W-1:0]  log_addr[$];
  logic [`SDRAM_BANK_W-1:0] log_bank[$];
  int                       log_cyc[$];
  int                       rgrant_cyc[$];
  int                       bgrant_cyc[$];

  sdram_ctrl_top u_dut (.*);

  sdram_cmd_monitor u_mon (
    .CLK        (CLK),
    .RST        (RST),
    .cmd        (cmd),
    .addr       (addr),
    .bank       (bank),
    .violations (violations),
    .page_open  (mon_open),
    .open_row   (mon_row),
    .open_bank  (mon_bank)
  );

  always #10 CLK = ~CLK;

  always @(posedge CLK)
  begin
    if (!RST)
      cyc = 0;
    else
    begin
      cyc = cyc + 1;
      if (cmd != sdram_pkg::NOOP)
      begin
        log_cmd.push_back(cmd);
        log_addr.push_back(addr);
        log_bank.push_back(bank);
        log_cyc.push_back(cyc);
      end
      if (rand_grant)
        rgrant_cyc.push_back(cyc);
      if (bulk_grant)
        bgrant_cyc.push_back(cyc);
    end
  end

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [`SDRAM_ADDR_W-1:0] random_address();
    logic [31:0] r;
    r = lcg_next();
    return r[31:6];  // upper bits are the better ones
  endfunction

  // expected bus words: row in [11:0] for ACTV, column in [12:1] for access
  function automatic logic [`SDRAM_BUS_W-1:0] row_word(input logic [`SDRAM_ADDR_W-1:0] a);
    return {1'b0, a[25:14]};
  endfunction

  function automatic logic [`SDRAM_BUS_W-1:0] col_word(input logic [`SDRAM_ADDR_W-1:0] a);
    return {a[11:0], 1'b0};
  endfunction

  task automatic check_value(input string what, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (actual !== expected)
    begin
      $display("Error %s: %s expected %0h actual %0h", test_name, what, expected, actual);
      errors++;
    end
  endtask

  task automatic check_cmd(input int idx, input sdram_pkg::sdram_cmd_e c,
                           input logic [`SDRAM_BUS_W-1:0] a, input logic [1:0] b);
    if (idx >= log_cmd.size())
    begin
      $display("%s: bus command number %0d never appeared", test_name, idx);
      errors++;
    end
    else
    begin
      check_value($sformatf("cmd %0d", idx), c, log_cmd[idx]);
      check_value($sformatf("addr %0d", idx), a, log_addr[idx]);
      if (c == sdram_pkg::ACTV || c == sdram_pkg::READ || c == sdram_pkg::WRTE)
        check_value($sformatf("bank %0d", idx), b, log_bank[idx]);
    end
  endtask

  // one grant cycle only, and on the same edge as the access command
  task automatic check_grant(input logic bulk, input int idx);
    int n;
    int c;
    n = bulk ? bgrant_cyc.size() : rgrant_cyc.size();
    check_value(bulk ? "bulk grant cycles" : "random grant cycles", 1, n);
    if (n == 1 && idx < log_cyc.size())
    begin
      c = bulk ? bgrant_cyc[0] : rgrant_cyc[0];
      check_value(bulk ? "bulk grant cycle" : "random grant cycle", log_cyc[idx], c);
    end
  endtask

  task automatic clear_log();
    @(negedge CLK);
    log_cmd.delete();
    log_addr.delete();
    log_bank.delete();
    log_cyc.delete();
    rgrant_cyc.delete();
    bgrant_cyc.delete();
  endtask

  task automatic port_access(input logic bulk, input logic [`SDRAM_ADDR_W-1:0] a,
                             input logic we, output int edges);
    logic got;
    got   = 1'b0;
    edges = 0;
    @(posedge CLK);
    if (bulk)
    begin
      bulk_addr <= a;
      bulk_we   <= we;
      bulk_req  <= 1'b1;
    end
    else
    begin
      rand_addr <= a;
      rand_we   <= we;
      rand_req  <= 1'b1;
    end
    while (!got && edges < 50)
    begin
      @(posedge CLK);
      edges++;
      got = bulk ? bulk_grant : rand_grant;
    end
    if (bulk)
      bulk_req <= 1'b0;
    else
      rand_req <= 1'b0;
    if (!got)
    begin
      $display("%s: no grant on the %s port within 50 cycles", test_name,
               bulk ? "bulk" : "random");
      errors++;
    end
  endtask

  task automatic start_test(input string name);
    test_name  = name;
    start_errs = errors;
    repeat (3) @(negedge CLK);  // let the previous spacing run out
    clear_log();
  endtask

  task automatic end_test();
    check_value("bus rule violations", 0, violations);
    if (errors == start_errs)
    begin
      $display("test %s: ok", test_name);
      passed++;
    end
    else
    begin
      $display("test %s: failed with %0d errors", test_name, errors - start_errs);
      failed++;
    end
  endtask

  task automatic test_reset();
    start_test("reset");
    check_value("cmd", sdram_pkg::NOOP, cmd);
    check_value("rand_grant", 0, rand_grant);
    check_value("bulk_grant", 0, bulk_grant);
    check_value("addr", 13'h0400, addr);
    end_test();
  endtask

  task automatic test_closed_page();
    int edges;
    start_test("closed_page");
    page_addr = random_address();
    port_access(1'b0, page_addr, 1'b0, edges);
    @(negedge CLK);
    check_value("commands", 2, log_cmd.size());
    check_cmd(0, sdram_pkg::ACTV, row_word(page_addr), page_addr[13:12]);
    check_cmd(1, sdram_pkg::READ, col_word(page_addr), page_addr[13:12]);
    check_grant(1'b0, 1);
    end_test();
  endtask

  task automatic test_page_hit();
    logic [`SDRAM_ADDR_W-1:0] b;
    int edges;
    start_test("page_hit");
    b = random_address();
    b[25:12] = page_addr[25:12];  // same row and bank, new column
    port_access(1'b1, b, 1'b1, edges);
    @(negedge CLK);
    check_value("hit latency", 2, edges);
    check_value("commands", 1, log_cmd.size());
    check_cmd(0, sdram_pkg::WRTE, col_word(b), b[13:12]);
    check_grant(1'b1, 0);
    end_test();
  endtask

  task automatic test_page_miss();
    logic [`SDRAM_ADDR_W-1:0] a;
    int edges;
    start_test("page_miss");
    a = random_address();
    if (a[25:14] == page_addr[25:14])
      a[14] = ~a[14];
    port_access(1'b0, a, 1'b0, edges);
    @(negedge CLK);
    check_value("commands", 3, log_cmd.size());
    check_cmd(0, sdram_pkg::PRCH, 13'h0400, 2'b00);
    check_cmd(1, sdram_pkg::ACTV, row_word(a), a[13:12]);
    check_cmd(2, sdram_pkg::READ, col_word(a), a[13:12]);
    check_grant(1'b0, 2);
    check_value("monitor row", a[25:14], mon_row);
    check_value("monitor bank", a[13:12], mon_bank);
    page_addr = a;
    end_test();
  endtask

  task automatic test_both_ports();
    logic [`SDRAM_ADDR_W-1:0] b;
    logic [`SDRAM_ADDR_W-1:0] r;
    int eb;
    int er;
    start_test("both_ports");
    b = random_address();
    r = random_address();
    b[25:12] = page_addr[25:12];
    r[25:12] = page_addr[25:12];
    fork
      port_access(1'b1, b, 1'b1, eb);
      port_access(1'b0, r, 1'b0, er);
    join
    @(negedge CLK);
    check_value("commands", 2, log_cmd.size());
    check_cmd(0, sdram_pkg::WRTE, col_word(b), b[13:12]);  // bulk goes first
    check_cmd(1, sdram_pkg::READ, col_word(r), r[13:12]);
    check_grant(1'b1, 0);
    check_grant(1'b0, 1);
    end_test();
  endtask

  task automatic test_refresh();
    logic found;
    int waited;
    int edges;
    start_test("refresh");
    found  = 1'b0;
    waited = 0;
    while (!found && waited < 2 * `SDRAM_REFRESH_PERIOD)
    begin
      @(negedge CLK);
      waited++;
      found = (log_cmd.size() > 0) && (log_cmd[log_cmd.size() - 1] == sdram_pkg::ARSR);
    end
    if (!found)
    begin
      $display("%s: no ARSR within %0d idle cycles", test_name, waited);
      errors++;
    end
    check_value("commands", 2, log_cmd.size());
    check_cmd(0, sdram_pkg::PRCH, 13'h0400, 2'b00);
    check_cmd(1, sdram_pkg::ARSR, 13'h0400, 2'b00);
    check_value("monitor page open", 0, mon_open);
    clear_log();
    port_access(1'b0, page_addr, 1'b0, edges);
    @(negedge CLK);
    check_value("commands after refresh", 2, log_cmd.size());
    check_cmd(0, sdram_pkg::ACTV, row_word(page_addr), page_addr[13:12]);
    check_cmd(1, sdram_pkg::READ, col_word(page_addr), page_addr[13:12]);
    end_test();
  endtask

  initial
  begin
    CLK       = 1'b0;
    RST       = 1'b0;
    rand_addr = '0;
    rand_we   = 1'b0;
    rand_req  = 1'b0;
    bulk_addr = '0;
    bulk_we   = 1'b0;
    bulk_req  = 1'b0;
    lcg_state = 32'h0da5_0c9f;
    errors    = 0;
    passed    = 0;
    failed    = 0;
    repeat (5) @(posedge CLK);
    RST <= 1'b1;
    test_reset();
    test_closed_page();
    test_page_hit();
    test_page_miss();
    test_both_ports();
    test_refresh();
    $display("tests passed %0d, tests failed %0d", passed, failed);
    if (failed == 0)
    begin
      $display("Result: PASSED");
    end
    else
    begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* flist.f */
+incdir+source
source/sdram_pkg.sv
source/refresh_timer.sv
source/page_tracker.sv
source/cmd_timer.sv
source/cmd_scheduler.sv
source/sdram_ctrl_top.sv
testbench/sdram_cmd_monitor.sv
testbench/sdram_ctrl_tb.sv
